// File: common/clock_timer_config.svh
`ifndef CLOCK_TIMER_CONFIG_SVH
`define CLOCK_TIMER_CONFIG_SVH

// Base clock cycles per 128 Hz step
// 32768 Hz base / 128 Hz = 256, any power of two works
`define CT_PRESCALE 256

// Register map on the nibble bus
`define CT_ADDR_FACTOR   12'hF00  // Factor flags, clear on read
`define CT_ADDR_MASK     12'hF10  // Interrupt mask, read/write
`define CT_ADDR_PHASE_LO 12'hF20  // Divider bits 3:0
`define CT_ADDR_PHASE_HI 12'hF21  // Divider bits 7:4
`define CT_ADDR_CONTROL  12'hF76  // Timer control, write only

// Control register bit that restarts both counters
// Other bits are ignored by the timer
`define CT_CTRL_RESET_BIT 1

`endif

// File: common/clock_timer_pkg.sv
package clock_timer_pkg;

    // One bus cycle from the CPU side
    // Nibble data bus, 12-bit address space
    // Level strobes, no handshake
    typedef struct packed {
        logic [11:0] addr;      // Memory-mapped address
        logic [3:0]  wdata;     // Nibble to write
        logic        wr;        // Write strobe, one edge per cycle held
        logic        rd;        // Read strobe, data valid same cycle
    } bus_req_t;

    // Which timer register the address hits
    typedef enum logic [2:0] {
        SEL_NONE     = 3'd0,    // Address outside the timer
        SEL_FACTOR   = 3'd1,    // 0xF00 interrupt factor flags
        SEL_MASK     = 3'd2,    // 0xF10 interrupt mask
        SEL_PHASE_LO = 3'd3,    // 0xF20 16 to 128 Hz stages
        SEL_PHASE_HI = 3'd4,    // 0xF21 1 to 8 Hz stages
        SEL_CONTROL  = 3'd5     // 0xF76 timer control
    } reg_sel_e;

    // Decoded access handed to the counter and factor blocks
    // wr and rd are only set on a register hit
    typedef struct packed {
        reg_sel_e   sel;        // Target register
        logic       wr;         // Qualified write
        logic       rd;         // Qualified read
        logic [3:0] data;       // Write data, straight from the bus
    } reg_access_t;

    // Period-end pulses, one cycle each
    // Listed slowest first so the packed value lines up with the factor nibble
    typedef struct packed {
        logic hz1;              // Factor bit 3
        logic hz2;              // Factor bit 2
        logic hz8;              // Factor bit 1
        logic hz32;             // Factor bit 0
    } period_tick_t;

    // Widths for reference
    //   bus_req_t     18 bits
    //   reg_access_t   9 bits
    //   period_tick_t  4 bits

endpackage

// File: src/bus_decode.sv
module bus_decode (
    input  clock_timer_pkg::bus_req_t    bus,
    output clock_timer_pkg::reg_access_t access
);
    import clock_timer_pkg::*;

    `include "clock_timer_config.svh"

    reg_sel_e sel;
    logic     hit;

    // Address compare against the register map
    always_comb begin
        sel = SEL_NONE;
        case (bus.addr)
            `CT_ADDR_FACTOR:   sel = SEL_FACTOR;
            `CT_ADDR_MASK:     sel = SEL_MASK;
            `CT_ADDR_PHASE_LO: sel = SEL_PHASE_LO;
            `CT_ADDR_PHASE_HI: sel = SEL_PHASE_HI;
            `CT_ADDR_CONTROL:  sel = SEL_CONTROL;
            default:           sel = SEL_NONE;  // Not a timer register
        endcase
    end

    assign hit = (sel != SEL_NONE);

    // Strobes only survive on a hit
    // so downstream blocks never see a stray access
    always_comb begin
        access.sel  = sel;
        access.wr   = bus.wr && hit;
        access.rd   = bus.rd && hit;
        access.data = bus.wdata;    // Data needs no qualifying
    end

endmodule

// File: clock_timer/clock_divider.sv
module clock_divider (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clock_timer_pkg::reg_access_t  access,
    output logic [7:0]                    phase,
    output clock_timer_pkg::period_tick_t ticks
);
    import clock_timer_pkg::*;

    `include "clock_timer_config.svh"

    // Prescaler width follows the configured length
    localparam int PRESCALE_W = $clog2(`CT_PRESCALE);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`CT_PRESCALE - 1);

    logic [PRESCALE_W-1:0] prescale_cnt;  // Base clock to 128 Hz
    logic [7:0]            divider;       // 128 Hz down to 1 Hz
    logic                  prescale_wrap;
    logic                  ctrl_reset;

    // Last base cycle of a 128 Hz step
    assign prescale_wrap = (prescale_cnt == PRESCALE_LAST);

    // Control write with the reset bit set
    // Any other pattern on the control register leaves the count alone
    assign ctrl_reset = access.wr
                     && (access.sel == SEL_CONTROL)
                     && access.data[`CT_CTRL_RESET_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prescale_cnt <= '0;
        end else if (ctrl_reset) begin
            prescale_cnt <= '0;                     // Restart from zero next cycle
        end else if (prescale_wrap) begin
            prescale_cnt <= '0;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    // Divider advances once per prescaler wrap
    // Wraps 255 to 0 by itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            divider <= '0;
        end else if (ctrl_reset) begin
            divider <= '0;
        end else if (prescale_wrap) begin
            divider <= divider + 1'b1;
        end
    end

    // Period ends
    // A period ends on the wrap where its low divider bits are all ones
    always_comb begin
        ticks.hz32 = prescale_wrap && (&divider[1:0]);  // Every 4 steps
        ticks.hz8  = prescale_wrap && (&divider[3:0]);  // Every 16 steps
        ticks.hz2  = prescale_wrap && (&divider[5:0]);  // Every 64 steps
        ticks.hz1  = prescale_wrap && (&divider[6:0]);  // Every 128 steps
    end

    // Phase read-back is the raw divider
    assign phase = divider;

endmodule

// File: clock_timer/interrupt_factor.sv
module interrupt_factor (
    input  logic                          clk,
    input  logic                          rst_n,
    input  clock_timer_pkg::reg_access_t  access,
    input  logic [7:0]                    phase,
    input  clock_timer_pkg::period_tick_t ticks,
    output logic [3:0]                    rdata,
    output logic                          irq
);
    import clock_timer_pkg::*;

    logic [3:0] factor;         // Bit 0 = 32 Hz .. bit 3 = 1 Hz
    logic [3:0] mask;           // Same bit order as factor
    logic [3:0] tick_vec;
    logic       factor_rd;
    logic       mask_wr;

    // Ticks packed into factor bit order
    assign tick_vec = {ticks.hz1, ticks.hz2, ticks.hz8, ticks.hz32};

    // Access qualifiers
    assign factor_rd = access.rd && (access.sel == SEL_FACTOR);
    assign mask_wr   = access.wr && (access.sel == SEL_MASK);

    // Factor flags
    // A read clears all flags at the edge that ends it
    // A tick on that same edge still sets its own bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            factor <= '0;
        end else if (factor_rd) begin
            factor <= tick_vec;
        end else begin
            factor <= factor | tick_vec;    // Sticky until read
        end
    end

    // Mask register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mask <= '0;
        end else if (mask_wr) begin
            mask <= access.data;
        end
    end

    // Request while any enabled flag is set
    // No register stage, follows factor and mask directly
    assign irq = |(factor & mask);

    // Read-back mux
    // Old flags are returned in the same cycle as the clearing read
    always_comb begin
        rdata = 4'h0;
        if (access.rd) begin
            case (access.sel)
                SEL_FACTOR:   rdata = factor;
                SEL_MASK:     rdata = mask;
                SEL_PHASE_LO: rdata = phase[3:0];   // 16..128 Hz stages
                SEL_PHASE_HI: rdata = phase[7:4];   // 1..8 Hz stages
                SEL_CONTROL:  rdata = 4'h0;         // Write only
                default:      rdata = 4'h0;
            endcase
        end
    end

endmodule

// File: src/clock_timer_top.sv
module clock_timer_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  clock_timer_pkg::bus_req_t  bus,
    output logic [3:0]                 rdata,
    output logic                       irq
);
    import clock_timer_pkg::*;

    reg_access_t  access;   // Decoded register access
    logic [7:0]   phase;    // Divider value for read-back
    period_tick_t ticks;    // Period-end pulses

    // Address decode, purely combinational
    bus_decode u_bus_decode (
        .bus    (bus),
        .access (access)
    );

    // Prescaler and phase divider
    clock_divider u_clock_divider (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (access),
        .phase  (phase),
        .ticks  (ticks)
    );

    // Flags, mask, interrupt and read data
    interrupt_factor u_interrupt_factor (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (access),
        .phase  (phase),
        .ticks  (ticks),
        .rdata  (rdata),
        .irq    (irq)
    );

endmodule

// File: test/clock_timer_model.svh
`ifndef CLOCK_TIMER_MODEL_SVH
`define CLOCK_TIMER_MODEL_SVH

`include "clock_timer_config.svh"

// Period lengths in base cycles
localparam int PERIOD_32HZ = 4 * `CT_PRESCALE;     // Low 2 divider bits
localparam int PERIOD_8HZ  = 16 * `CT_PRESCALE;    // Low 4 bits
localparam int PERIOD_2HZ  = 64 * `CT_PRESCALE;    // Low 6 bits
localparam int PERIOD_1HZ  = 128 * `CT_PRESCALE;   // Low 7 bits, one second of base clock

// Flags raised on the edge that ends the cycle at this count
// A period ends when the next count is a whole number of periods
function automatic logic [3:0] expected_ticks(int count);
    expected_ticks[0] = ((count + 1) % PERIOD_32HZ) == 0;
    expected_ticks[1] = ((count + 1) % PERIOD_8HZ) == 0;
    expected_ticks[2] = ((count + 1) % PERIOD_2HZ) == 0;
    expected_ticks[3] = ((count + 1) % PERIOD_1HZ) == 0;
endfunction

// Whole 128 Hz steps since the counters were zeroed
function automatic logic [7:0] expected_phase(int count);
    return 8'((count / `CT_PRESCALE) % 256);
endfunction

function automatic logic [3:0] expected_rdata(logic [11:0] addr, logic [3:0] flags,
                                              logic [3:0] mask, int count);
    logic [7:0] phase;
    phase = expected_phase(count);
    case (addr)
        `CT_ADDR_FACTOR:   return flags;
        `CT_ADDR_MASK:     return mask;
        `CT_ADDR_PHASE_LO: return phase[3:0];
        `CT_ADDR_PHASE_HI: return phase[7:4];
        default:           return 4'h0;    // Write-only control and misses read zero
    endcase
endfunction

function automatic logic expected_irq(logic [3:0] flags, logic [3:0] mask);
    return |(flags & mask);
endfunction

// Fibonacci LFSR with taps 32 22 2 1
// One step per bit
function automatic logic [31:0] take_bits(int n);
    logic [31:0] bits;
    logic        feedback;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        bits = {bits[30:0], feedback};
    end
    return bits;
endfunction

task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
        error_count++;
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
endtask

`endif

// File: test/clock_timer_tb.sv
module clock_timer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import clock_timer_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;    // After each rising edge
    localparam int RESET_CYCLES = 16;

    // Cycle budget of each test from the waits it makes
    localparam int BUDGET_CYCLES = RESET_CYCLES
                                 + 33000    // Factor timing up to the 1 Hz end
                                 + 8000     // Clear on read
                                 + 12000    // Eight 32 Hz periods
                                 + 200      // Mask readback
                                 + 6000     // Phase reads
                                 + 10000;   // Control restart
    localparam longint WATCHDOG_NS = longint'(BUDGET_CYCLES) * CLK_PERIOD * 11 / 10;

    logic       clk;
    logic       rst_n;
    bus_req_t   bus;
    logic [3:0] rdata;
    logic       irq;

    // Reference state stepped on each rising edge
    int         model_count;    // Edges since the counters were zeroed
    logic [3:0] model_flags;
    logic [3:0] model_mask;

    logic [31:0] lfsr_state;
    string       test_name;
    int          error_count;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;

    `include "clock_timer_model.svh"

    clock_timer_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .rdata (rdata),
        .irq   (irq)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Model follows the same bus values the DUT samples
    always @(posedge clk) begin : model_update
        logic [3:0] tick_now;
        tick_now = expected_ticks(model_count);     // From the count before this edge
        if (!rst_n) begin
            model_count = 0;
            model_flags = 4'h0;
            model_mask  = 4'h0;
        end else begin
            if (bus.rd && bus.addr == `CT_ADDR_FACTOR)
                model_flags = tick_now;             // Cleared but a tick still wins
            else
                model_flags = model_flags | tick_now;
            if (bus.wr && bus.addr == `CT_ADDR_MASK)
                model_mask = bus.wdata;
            if (bus.wr && bus.addr == `CT_ADDR_CONTROL && bus.wdata[`CT_CTRL_RESET_BIT])
                model_count = 0;
            else
                model_count++;
        end
    end

    // Read data is combinational and settled mid-cycle
    always @(negedge clk) begin : compare
        if (rst_n && bus.rd) begin
            check("rdata", expected_rdata(bus.addr, model_flags, model_mask, model_count),
                  rdata);
            check("irq", expected_irq(model_flags, model_mask), irq);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, error_count - errors_at_start);
        end
    endtask

    // All bus tasks start and end just after the drive point
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_count(input int target);
        while (model_count != target) idle_cycles(1);
    endtask

    task automatic write_reg(input logic [11:0] addr, input logic [3:0] data);
        bus.addr  = addr;
        bus.wdata = data;
        bus.wr    = 1'b1;
        idle_cycles(1);
        bus = '0;
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [3:0] data);
        bus.addr = addr;
        bus.rd   = 1'b1;
        @(negedge clk);
        data = rdata;
        @(posedge clk);     // Side effects land here
        #DRIVE_DELAY;
        bus = '0;
    endtask

    task automatic factor_timing();
        int         periods[4];
        logic [3:0] pattern;
        logic [3:0] value;
        periods = '{PERIOD_32HZ, PERIOD_8HZ, PERIOD_2HZ, PERIOD_1HZ};
        pattern = 4'h0;
        begin_test("factor_timing");
        for (int i = 0; i < 4; i++) begin
            pattern[i] = 1'b1;      // Faster flags end on the same edge
            wait_count(periods[i] - 2);
            read_reg(`CT_ADDR_FACTOR, value);   // Drop flags left from earlier
            read_reg(`CT_ADDR_FACTOR, value);
            check("factor one edge early", 4'h0, value);
            read_reg(`CT_ADDR_FACTOR, value);
            check("factor at period end", pattern, value);
        end
        end_test();
    endtask

    task automatic clear_on_read();
        logic [3:0] first;
        logic [3:0] second;
        logic [3:0] tick_between;
        begin_test("clear_on_read");
        for (int i = 0; i < 7; i++) begin
            if (i == 6)
                wait_count((model_count / PERIOD_32HZ + 1) * PERIOD_32HZ - 1);  // Clear on a tick
            else
                idle_cycles(take_bits(8) + 1);
            tick_between = expected_ticks(model_count);
            read_reg(`CT_ADDR_FACTOR, first);
            read_reg(`CT_ADDR_FACTOR, second);
            check("factor after clear", tick_between, second);
        end
        end_test();
    endtask

    task automatic irq_follows_mask();
        logic [3:0] new_mask;
        logic [3:0] value;
        begin_test("irq_follows_mask");
        for (int i = 0; i < 8; i++) begin
            new_mask = 4'(take_bits(4));
            write_reg(`CT_ADDR_MASK, new_mask);
            wait_count((model_count / PERIOD_32HZ + 1) * PERIOD_32HZ);
            read_reg(`CT_ADDR_MASK, value);     // irq with the fresh flags
            read_reg(`CT_ADDR_FACTOR, value);
            read_reg(`CT_ADDR_MASK, value);     // irq after the clear
        end
        end_test();
    endtask

    task automatic mask_readback();
        logic [3:0] wr_value;
        logic [3:0] rd_value;
        begin_test("mask_readback");
        for (int i = 0; i < 16; i++) begin
            wr_value = 4'(take_bits(4));
            write_reg(`CT_ADDR_MASK, wr_value);
            read_reg(`CT_ADDR_MASK, rd_value);
            check("mask readback", wr_value, rd_value);
        end
        read_reg(`CT_ADDR_CONTROL, rd_value);
        check("control read", 4'h0, rd_value);
        read_reg(12'hF30, rd_value);            // Outside the timer
        check("unmapped read", 4'h0, rd_value);
        end_test();
    endtask

    task automatic phase_readback();
        logic [3:0] value;
        logic [7:0] phase;
        begin_test("phase_readback");
        for (int i = 0; i < 16; i++) begin
            idle_cycles(take_bits(8) + 1);
            phase = expected_phase(model_count);
            read_reg(`CT_ADDR_PHASE_LO, value);
            check("phase low nibble", phase[3:0], value);
            phase = expected_phase(model_count);
            read_reg(`CT_ADDR_PHASE_HI, value);
            check("phase high nibble", phase[7:4], value);
        end
        end_test();
    endtask

    task automatic control_restart();
        logic [3:0] value;
        logic [3:0] keep[5];
        logic [7:0] phase;
        int         count_before;
        keep = '{4'h0, 4'h1, 4'h4, 4'h8, 4'hd};    // Reset bit clear in all
        begin_test("control_restart");
        read_reg(`CT_ADDR_FACTOR, value);
        write_reg(`CT_ADDR_CONTROL, 4'(1 << `CT_CTRL_RESET_BIT));
        read_reg(`CT_ADDR_PHASE_LO, value);
        check("phase low after restart", 4'h0, value);
        read_reg(`CT_ADDR_PHASE_HI, value);
        check("phase high after restart", 4'h0, value);
        wait_count(PERIOD_8HZ - 2);
        read_reg(`CT_ADDR_FACTOR, value);       // 32 Hz flags from the first quarter
        read_reg(`CT_ADDR_FACTOR, value);
        check("8 Hz flag early", 1'b0, value[1]);
        read_reg(`CT_ADDR_FACTOR, value);
        check("8 Hz flag after restart", 1'b1, value[1]);
        for (int i = 0; i < 5; i++) begin
            idle_cycles(take_bits(8) + 1);
            count_before = model_count;
            write_reg(`CT_ADDR_CONTROL, keep[i]);
            phase = expected_phase(count_before + 1);
            read_reg(`CT_ADDR_PHASE_LO, value);
            check("phase low kept", phase[3:0], value);
            phase = expected_phase(count_before + 2);
            read_reg(`CT_ADDR_PHASE_HI, value);
            check("phase high kept", phase[7:4], value);
        end
        end_test();
    endtask

    initial begin : main
        rst_n           = 1'b0;
        bus             = '0;
        lfsr_state      = 32'h8e2a;
        error_count     = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        test_name       = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        factor_timing();
        clear_on_read();
        irq_follows_mask();
        mask_readback();
        phase_readback();
        control_restart();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+common
+incdir+test
common/clock_timer_pkg.sv
src/bus_decode.sv
clock_timer/clock_divider.sv
clock_timer/interrupt_factor.sv
src/clock_timer_top.sv
test/clock_timer_tb.sv
